/* Makefile */
TOP := lsu_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

/* bench/lsu_asserts.sv */
`timescale 1ns/1ns

module lsu_asserts (
    input logic              clk,
    input logic              rst,
    input logic              mem_req_valid_i,
    input lsu_pkg::mem_req_t mem_req_i,
    input logic              mem_rsp_valid_i,
    input logic              res_valid_i,
    input lsu_pkg::lsu_res_t res_i,
    input logic              res_ready_i
);

    int unsigned fail_count = 0;    // failed assertions so far

    // access held until the response pulse
    mem_req_held: assert property (
        @(posedge clk) disable iff (rst)
        mem_req_valid_i && !mem_rsp_valid_i |=> mem_req_valid_i && $stable(mem_req_i)
    ) else begin
        fail_count++;
        $error("memory request changed before its response");
    end

    res_held: assert property (
        @(posedge clk) disable iff (rst)
        res_valid_i && !res_ready_i |=> res_valid_i && $stable(res_i)
    ) else begin
        fail_count++;
        $error("result changed while res_ready_i was low");
    end

    // first cycle out of reset
    valids_after_reset: assert property (
        @(posedge clk) $fell(rst) |-> !mem_req_valid_i && !res_valid_i
    ) else begin
        fail_count++;
        $error("valid output high right after reset release");
    end

endmodule : lsu_asserts

bind lsu_top lsu_asserts lsu_asserts_inst (
    .clk             (clk),
    .rst             (rst),
    .mem_req_valid_i (mem_req_valid_o),
    .mem_req_i       (mem_req_o),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .res_valid_i     (res_valid_o),
    .res_i           (res_o),
    .res_ready_i     (res_ready_i)
);

/* bench/lsu_tb.sv */
`timescale 1ns/1ns
`include "lsu_macros.svh"

module lsu_tb;

    logic              clk;
    logic              rst;
    logic              req_valid_i;
    lsu_pkg::lsu_req_t req_i;
    logic              req_ready_o;
    logic              mem_req_valid_o;
    lsu_pkg::mem_req_t mem_req_o;
    logic              mem_rsp_valid_i;
    lsu_pkg::word_t    mem_rsp_rdata_i;
    logic              res_valid_o;
    lsu_pkg::lsu_res_t res_o;
    logic              res_ready_i;

    lsu_pkg::word_t    mem [64];      // written by the DUT through the memory port
    lsu_pkg::word_t    shadow [64];   // reference copy, updated in request order
    lsu_pkg::lsu_res_t exp_res [$];
    lsu_pkg::mem_req_t exp_mem [$];
    lsu_pkg::order_t   next_order;
    int unsigned       errors;
    int unsigned       checks;
    int unsigned       lat_left;
    logic              in_access;
    logic              rand_stall;    // random res_ready_i when set

    lsu_top lsu_top_inst (
        .clk             (clk),
        .rst             (rst),
        .req_valid_i     (req_valid_i),
        .req_i           (req_i),
        .req_ready_o     (req_ready_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_o       (mem_req_o),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_rdata_i (mem_rsp_rdata_i),
        .res_valid_o     (res_valid_o),
        .res_o           (res_o),
        .res_ready_i     (res_ready_i)
    );

    always #10 clk = ~clk;

    function automatic lsu_pkg::word_t fill_word(int unsigned idx);
        return (idx * 32'h0104_0b1d) ^ 32'hc3a5_5a3c ^ (idx << 27);
    endfunction

    task automatic check_val(string name, lsu_pkg::word_t got, lsu_pkg::word_t exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    // reference model of one request, applied in transfer order
    task automatic expect_req(lsu_pkg::lsu_req_t r);
        lsu_pkg::word_t    eff;
        lsu_pkg::word_t    word;
        lsu_pkg::word_t    shifted;
        lsu_pkg::mem_req_t m;
        lsu_pkg::lsu_res_t e;
        logic [1:0]        lane;
        logic              bad;
        int                b;
        eff  = r.base + r.offset;
        lane = eff[1:0];
        bad  = !(r.funct3 inside {`LSU_F3_B, `LSU_F3_H, `LSU_F3_W, `LSU_F3_BU, `LSU_F3_HU})
               || (r.is_store && r.funct3[2]);  // no unsigned stores
        m.write   = r.is_store;
        m.addr    = {eff[31:2], 2'b00};
        m.wdata   = r.wdata << (8 * lane);
        m.byte_en = (r.funct3[1:0] == 2'd0) ? (4'b0001 << lane) : (4'b0011 << lane);
        if (r.funct3 == `LSU_F3_W) begin
            m.addr    = eff;
            m.wdata   = r.wdata;
            m.byte_en = 4'hf;
        end
        word    = shadow[m.addr[7:2]];
        shifted = word >> (8 * lane);
        case (r.funct3)
            `LSU_F3_B:  e.rd_wdata = {{24{shifted[7]}}, shifted[7:0]};
            `LSU_F3_BU: e.rd_wdata = {24'h0, shifted[7:0]};
            `LSU_F3_H:  e.rd_wdata = {{16{shifted[15]}}, shifted[15:0]};
            `LSU_F3_HU: e.rd_wdata = {16'h0, shifted[15:0]};
            default:    e.rd_wdata = word;
        endcase
        e.order   = next_order;
        e.rd      = r.rd;
        e.is_load = !r.is_store && !bad;
        e.trap    = bad;
        if (!e.is_load) begin
            e.rd_wdata = 32'h0;
        end
        if (!bad) begin
            exp_mem.push_back(m);
            for (b = 0; b < 4; b++) begin
                if (r.is_store && m.byte_en[b]) begin
                    shadow[m.addr[7:2]][8*b +: 8] = m.wdata[8*b +: 8];
                end
            end
        end
        exp_res.push_back(e);
        next_order++;
    endtask

    // called 1 ns after a rising edge, returns at the same point
    task automatic send(input logic st, input lsu_pkg::funct3_t f3, input lsu_pkg::word_t base,
                        input lsu_pkg::word_t offset, input lsu_pkg::word_t wdata,
                        input lsu_pkg::reg_addr_t rd);
        int unsigned waited;
        req_i.is_store = st;
        req_i.funct3   = f3;
        req_i.base     = base;
        req_i.offset   = offset;
        req_i.wdata    = wdata;
        req_i.rd       = rd;
        req_valid_i    = 1'b1;
        waited         = 0;
        @(negedge clk);
        while (!req_ready_o && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (req_ready_o) begin
            expect_req(req_i);  // transfers on the coming edge
        end else begin
            errors++;
            $display("request was not accepted within 200 cycles");
        end
        @(posedge clk);
        #1;
        req_valid_i = 1'b0;
    endtask

    // returns 1 ns after a rising edge, once every result has left
    task automatic drain();
        int unsigned waited;
        waited = 0;
        while (exp_res.size() != 0 && waited < 1000) begin
            @(negedge clk);
            waited++;
        end
        if (exp_res.size() != 0) begin
            errors++;
            $display("timed out with %0d results still outstanding", exp_res.size());
        end
        if (exp_mem.size() != 0) begin
            errors++;
            $display("%0d expected memory requests never appeared", exp_mem.size());
        end
        @(posedge clk);
        #1;
    endtask

    task automatic check_mem_req();
        lsu_pkg::mem_req_t m;
        if (exp_mem.size() == 0) begin
            errors++;
            $display("memory request seen while none was expected");
        end else begin
            m = exp_mem.pop_front();
            check_val("mem_req_o.write", 32'(mem_req_o.write), 32'(m.write));
            check_val("mem_req_o.addr", mem_req_o.addr, m.addr);
            check_val("mem_req_o.byte_en", 32'(mem_req_o.byte_en), 32'(m.byte_en));
            if (m.write) begin
                check_val("mem_req_o.wdata", mem_req_o.wdata, m.wdata);
            end
        end
    endtask

    // answers each access after 1 to 4 cycles
    initial begin : memory_model
        logic [5:0] idx;
        int         b;
        int         k;
        mem_rsp_valid_i = 1'b0;
        mem_rsp_rdata_i = '0;
        in_access       = 1'b0;
        lat_left        = 0;
        for (k = 0; k < 64; k++) begin
            mem[k] = fill_word(k);
        end
        forever begin
            @(posedge clk);
            #1;
            mem_rsp_valid_i = 1'b0;
            if (rst) begin
                in_access = 1'b0;
            end else if (in_access) begin
                lat_left = lat_left - 1;
                if (lat_left == 0) begin
                    idx             = mem_req_o.addr[7:2];
                    mem_rsp_rdata_i = mem[idx];
                    for (b = 0; b < 4; b++) begin
                        if (mem_req_o.write && mem_req_o.byte_en[b]) begin
                            mem[idx][8*b +: 8] = mem_req_o.wdata[8*b +: 8];
                        end
                    end
                    mem_rsp_valid_i = 1'b1;
                    in_access       = 1'b0;
                end
            end else if (mem_req_valid_o) begin
                check_mem_req();
                in_access = 1'b1;
                lat_left  = $urandom_range(4, 1);
            end
        end
    end

    initial begin : ready_drive
        res_ready_i = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            res_ready_i = rand_stall ? ($urandom_range(2, 0) != 0) : 1'b1;
        end
    end

    initial begin : result_check
        lsu_pkg::lsu_res_t e;
        forever begin
            @(negedge clk);
            if (!rst && res_valid_o && res_ready_i) begin
                if (exp_res.size() == 0) begin
                    errors++;
                    $display("result seen while none was expected");
                end else begin
                    e = exp_res.pop_front();
                    check_val("res_o.order", res_o.order, e.order);
                    check_val("res_o.rd", 32'(res_o.rd), 32'(e.rd));
                    check_val("res_o.rd_wdata", res_o.rd_wdata, e.rd_wdata);
                    check_val("res_o.is_load", 32'(res_o.is_load), 32'(e.is_load));
                    check_val("res_o.trap", 32'(res_o.trap), 32'(e.trap));
                end
            end
        end
    end

    initial begin : stimulus
        logic             st;
        lsu_pkg::funct3_t f3;
        lsu_pkg::word_t   off;
        int               k;
        void'($urandom(32'hd38f7d00));
        clk         = 1'b0;
        rst         = 1'b1;
        req_valid_i = 1'b0;
        req_i       = '0;
        rand_stall  = 1'b0;
        errors      = 0;
        checks      = 0;
        next_order  = '0;
        for (k = 0; k < 64; k++) begin
            shadow[k] = fill_word(k);
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_val("req_ready_o", 32'(req_ready_o), 32'h0);
        @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_val("mem_req_valid_o", 32'(mem_req_valid_o), 32'h0);
        check_val("res_valid_o", 32'(res_valid_o), 32'h0);
        @(posedge clk);
        #1;

        send(1'b1, `LSU_F3_W, 32'h40, 32'h0, 32'hdead_beef, 5'd1);
        send(1'b0, `LSU_F3_W, 32'h50, 32'hffff_fff0, 32'h0, 5'd2);  // negative offset
        for (k = 0; k < 4; k++) begin
            send(1'b1, `LSU_F3_B, 32'h80, 32'(k), 32'h1234_56a0 | 32'(k), 5'(k + 3));
        end
        send(1'b1, `LSU_F3_H, 32'h90, 32'h0, 32'hcafe_8001, 5'd7);
        send(1'b1, `LSU_F3_H, 32'h90, 32'h2, 32'h5555_7f02, 5'd8);
        send(1'b1, `LSU_F3_B, 32'h9c, 32'h2, 32'hffff_ff99, 5'd9);
        send(1'b0, `LSU_F3_W, 32'h80, 32'h0, 32'h0, 5'd10);
        send(1'b0, `LSU_F3_W, 32'h90, 32'h0, 32'h0, 5'd11);
        send(1'b0, `LSU_F3_W, 32'h9c, 32'h0, 32'h0, 5'd12);

        // narrow loads over a word with mixed sign bits
        send(1'b1, `LSU_F3_W, 32'ha0, 32'h0, 32'h80f1_7f82, 5'd13);
        for (k = 0; k < 4; k++) begin
            send(1'b0, `LSU_F3_B, 32'ha0, 32'(k), 32'h0, 5'(k));
            send(1'b0, `LSU_F3_BU, 32'ha0, 32'(k), 32'h0, 5'(k + 4));
        end
        for (k = 0; k < 4; k += 2) begin
            send(1'b0, `LSU_F3_H, 32'ha0, 32'(k), 32'h0, 5'(k + 16));
            send(1'b0, `LSU_F3_HU, 32'ha0, 32'(k), 32'h0, 5'(k + 17));
            send(1'b0, `LSU_F3_H, 32'hb4, 32'(k), 32'h0, 5'(k + 20));
        end

        send(1'b0, 3'd3, 32'h40, 32'h0, 32'h0, 5'd21);
        send(1'b0, 3'd6, 32'h40, 32'h0, 32'h0, 5'd22);
        send(1'b0, 3'd7, 32'h40, 32'h0, 32'h0, 5'd23);
        send(1'b1, `LSU_F3_BU, 32'h40, 32'h1, 32'h1111_1111, 5'd24);
        send(1'b1, `LSU_F3_HU, 32'h40, 32'h0, 32'h2222_2222, 5'd25);
        send(1'b1, 3'd3, 32'h40, 32'h0, 32'h3333_3333, 5'd26);
        send(1'b0, `LSU_F3_W, 32'h40, 32'h0, 32'h0, 5'd27);   // unchanged by the traps
        drain();

        rand_stall = 1'b1;
        for (k = 0; k < 40; k++) begin
            st = ($urandom_range(1, 0) == 1);
            f3 = 3'($urandom_range(7, 0));
            if (f3[1:0] == 2'b10) begin
                off = 32'h0;
            end else if (f3[1:0] == 2'b01) begin
                off = 32'($urandom_range(1, 0)) << 1;
            end else begin
                off = 32'($urandom_range(3, 0));
            end
            send(st, f3, 32'($urandom_range(63, 0)) << 2, off, $urandom(),
                 5'($urandom_range(31, 0)));
        end
        drain();
        rand_stall = 1'b0;

        errors += lsu_top_inst.lsu_asserts_inst.fail_count;
        $display("checks %0d, errors %0d, results left %0d", checks, errors, exp_res.size());
        if (errors == 0 && exp_res.size() == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule : lsu_tb

/* hw/lsu_addr_gen.sv */
`timescale 1ns/1ns
`include "lsu_macros.svh"

module lsu_addr_gen (
    input  logic              clk,
    input  logic              rst,
    input  logic              op_valid_i,
    input  lsu_pkg::lsu_op_t  op_i,
    output logic              op_ready_o,
    output logic              mem_req_valid_o,
    output lsu_pkg::mem_req_t mem_req_o,
    input  logic              mem_rsp_valid_i,
    input  lsu_pkg::word_t    mem_rsp_rdata_i,
    output logic              done_valid_o,
    output lsu_pkg::lsu_op_t  done_op_o,
    output lsu_pkg::word_t    done_rdata_o,
    output lsu_pkg::byte_en_t done_byte_en_o,
    input  logic              done_ready_i
);

    lsu_pkg::stage_state_t state_q;
    lsu_pkg::stage_state_t state_d;
    lsu_pkg::lsu_op_t      op_q;
    lsu_pkg::mem_req_t     access_q;
    lsu_pkg::word_t        rdata_q;

    lsu_pkg::word_t    eff_addr;
    lsu_pkg::funct3_t  f3;
    logic [1:0]        lane;
    lsu_pkg::mem_req_t access;
    logic              trap;
    logic              take;

    assign op_ready_o = (state_q == lsu_pkg::st_idle) ||
                        (state_q == lsu_pkg::st_done && done_ready_i);
    assign take       = op_valid_i && op_ready_o;

    assign mem_req_valid_o = (state_q == lsu_pkg::st_wait_mem);
    assign mem_req_o       = access_q;
    assign done_valid_o    = (state_q == lsu_pkg::st_done);
    assign done_op_o       = op_q;
    assign done_rdata_o    = rdata_q;
    assign done_byte_en_o  = access_q.byte_en;  // zero marks a trapped item

    // address, lane mask and store shift
    always_comb begin : lane_calc
        eff_addr = op_i.req.base + op_i.req.offset;
        f3       = op_i.req.funct3;
        lane     = eff_addr[1:0];
        trap     = 1'b0;

        access.write   = op_i.req.is_store;
        access.addr    = {eff_addr[31:2], 2'b00};   // round down
        access.wdata   = op_i.req.wdata << {lane, 3'b000};
        access.byte_en = 4'b0000;

        case (f3)
            `LSU_F3_W: begin
                access.addr    = eff_addr;
                access.wdata   = op_i.req.wdata;
                access.byte_en = 4'b1111;
            end
            `LSU_F3_H, `LSU_F3_HU: access.byte_en = 4'b0011 << lane;
            `LSU_F3_B, `LSU_F3_BU: access.byte_en = 4'b0001 << lane;
            default:               trap = 1'b1;
        endcase

        // unsigned sizes have no store form
        if (op_i.req.is_store && (f3 == `LSU_F3_BU || f3 == `LSU_F3_HU)) begin
            trap = 1'b1;
        end
        if (trap) begin
            access.byte_en = 4'b0000;
        end
    end

    always_comb begin : next_state
        state_d = state_q;
        case (state_q)
            lsu_pkg::st_idle: begin
                if (take) begin
                    state_d = trap ? lsu_pkg::st_done : lsu_pkg::st_wait_mem;
                end
            end
            lsu_pkg::st_wait_mem: begin
                if (mem_rsp_valid_i) begin
                    state_d = lsu_pkg::st_done;
                end
            end
            lsu_pkg::st_done: begin
                if (take) begin     // back to back item
                    state_d = trap ? lsu_pkg::st_done : lsu_pkg::st_wait_mem;
                end else if (done_ready_i) begin
                    state_d = lsu_pkg::st_idle;
                end
            end
            default: state_d = lsu_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin : state_reg
        if (rst) begin
            state_q <= lsu_pkg::st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin : payload_reg
        if (take) begin
            op_q     <= op_i;
            access_q <= access;     // held stable for the whole access
        end
        if (state_q == lsu_pkg::st_wait_mem && mem_rsp_valid_i) begin
            rdata_q <= mem_rsp_rdata_i;
        end
    end

endmodule : lsu_addr_gen

/* hw/lsu_issue_reg.sv */
`timescale 1ns/1ns
`include "lsu_macros.svh"

module lsu_issue_reg (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid_i,
    input  lsu_pkg::lsu_req_t req_i,
    output logic              req_ready_o,
    output logic              op_valid_o,
    output lsu_pkg::lsu_op_t  op_o,
    input  logic              op_ready_i
);

    logic             live_q;      // set on the first edge after reset
    logic             valid_q;
    lsu_pkg::lsu_op_t op_q;
    lsu_pkg::order_t  order_q;
    lsu_pkg::order_t  order_next;
    logic             take;

    assign order_next  = order_q + 32'd1;
    assign req_ready_o = live_q && (!valid_q || op_ready_i); // empty or draining
    assign take        = req_valid_i && req_ready_o;

    assign op_valid_o = valid_q;
    assign op_o       = op_q;

    always_ff @(posedge clk, posedge rst) begin : live_reg
        if (rst) begin
            live_q <= 1'b0;
        end else begin
            live_q <= 1'b1;
        end
    end

    // valid flag and commit order counter
    always_ff @(posedge clk, posedge rst) begin : ctrl_reg
        if (rst) begin
            valid_q <= 1'b0;
            order_q <= `LSU_ORDER_INIT;
        end else begin
            if (take) begin
                valid_q <= 1'b1;
                order_q <= order_next;  // one per transfer
            end else if (op_ready_i) begin
                valid_q <= 1'b0;        // entry left downstream
            end
        end
    end

    always_ff @(posedge clk) begin : entry_reg
        if (take) begin
            op_q.req   <= req_i;
            op_q.order <= order_next;   // stamp with the new count
        end
    end

endmodule : lsu_issue_reg

/* hw/lsu_load_align.sv */
`timescale 1ns/1ns
`include "lsu_macros.svh"

module lsu_load_align (
    input  logic              clk,
    input  logic              rst,
    input  logic              done_valid_i,
    input  lsu_pkg::lsu_op_t  done_op_i,
    input  lsu_pkg::word_t    done_rdata_i,
    input  lsu_pkg::byte_en_t done_byte_en_i,
    output logic              done_ready_o,
    output logic              res_valid_o,
    output lsu_pkg::lsu_res_t res_o,
    input  logic              res_ready_i
);

    logic              valid_q;
    lsu_pkg::lsu_res_t res_q;

    logic              take;
    logic              is_trap;
    logic [7:0]        ld_byte;
    logic [15:0]       ld_half;
    lsu_pkg::word_t    ld_value;
    lsu_pkg::lsu_res_t res_d;

    assign done_ready_o = !valid_q || res_ready_i;
    assign take         = done_valid_i && done_ready_o;
    assign is_trap      = (done_byte_en_i == 4'b0000);

    assign res_valid_o = valid_q;
    assign res_o       = res_q;

    // pick the lane named by the byte enable
    always_comb begin : lane_select
        case (done_byte_en_i)
            4'b0010: ld_byte = done_rdata_i[15:8];
            4'b0100: ld_byte = done_rdata_i[23:16];
            4'b1000: ld_byte = done_rdata_i[31:24];
            default: ld_byte = done_rdata_i[7:0];
        endcase
        ld_half = done_byte_en_i[3] ? done_rdata_i[31:16] : done_rdata_i[15:0];
    end

    always_comb begin : extend
        case (done_op_i.req.funct3)
            `LSU_F3_B:  ld_value = {{24{ld_byte[7]}}, ld_byte};
            `LSU_F3_BU: ld_value = {24'h0, ld_byte};
            `LSU_F3_H:  ld_value = {{16{ld_half[15]}}, ld_half};
            `LSU_F3_HU: ld_value = {16'h0, ld_half};
            default:    ld_value = done_rdata_i;   // full word
        endcase
    end

    always_comb begin : result_build
        res_d.order    = done_op_i.order;
        res_d.rd       = done_op_i.req.rd;
        res_d.is_load  = !done_op_i.req.is_store && !is_trap;
        res_d.trap     = is_trap;
        res_d.rd_wdata = res_d.is_load ? ld_value : 32'h0;  // stores write nothing back
    end

    always_ff @(posedge clk, posedge rst) begin : valid_reg
        if (rst) begin
            valid_q <= 1'b0;
        end else if (take) begin
            valid_q <= 1'b1;
        end else if (res_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin : result_reg
        if (take) begin
            res_q <= res_d;
        end
    end

endmodule : lsu_load_align

/* hw/lsu_macros.svh */
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// word geometry of the RV32I data path
`define LSU_XLEN    32
`define LSU_NBYTES  4
`define LSU_REG_W   5

// funct3 access size codes, BU and HU are load only
`define LSU_F3_B    3'd0
`define LSU_F3_H    3'd1
`define LSU_F3_W    3'd2
`define LSU_F3_BU   3'd4
`define LSU_F3_HU   3'd5

`define LSU_ORDER_INIT  32'hffff_ffff   // first increment gives order 0

`endif

/* hw/lsu_pkg.sv */
`include "lsu_macros.svh"

package lsu_pkg;

    typedef logic [`LSU_XLEN-1:0]   word_t;     // data or address word
    typedef logic [`LSU_XLEN-1:0]   order_t;    // commit order number
    typedef logic [`LSU_REG_W-1:0]  reg_addr_t;
    typedef logic [`LSU_NBYTES-1:0] byte_en_t;  // one bit per byte lane
    typedef logic [2:0]             funct3_t;

    // request as it arrives from the execute side
    typedef struct packed {
        logic      is_store;
        funct3_t   funct3;
        word_t     base;
        word_t     offset;
        word_t     wdata;
        reg_addr_t rd;
    } lsu_req_t;

    // request after issue, stamped with its order
    typedef struct packed {
        lsu_req_t req;
        order_t   order;
    } lsu_op_t;

    typedef struct packed {
        logic     write;
        word_t    addr;     // word aligned except for word accesses
        word_t    wdata;    // already lane shifted
        byte_en_t byte_en;
    } mem_req_t;

    typedef struct packed {
        order_t    order;
        reg_addr_t rd;
        word_t     rd_wdata;
        logic      is_load;
        logic      trap;
    } lsu_res_t;

    // memory stage FSM
    typedef enum logic [1:0] {
        st_idle,
        st_wait_mem,
        st_done
    } stage_state_t;

endpackage : lsu_pkg

/* hw/lsu_top.sv */
`timescale 1ns/1ns

module lsu_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid_i,
    input  lsu_pkg::lsu_req_t req_i,
    output logic              req_ready_o,
    output logic              mem_req_valid_o,
    output lsu_pkg::mem_req_t mem_req_o,
    input  logic              mem_rsp_valid_i,
    input  lsu_pkg::word_t    mem_rsp_rdata_i,
    output logic              res_valid_o,
    output lsu_pkg::lsu_res_t res_o,
    input  logic              res_ready_i
);

    // issue to memory stage
    logic              op_valid;
    logic              op_ready;
    lsu_pkg::lsu_op_t  op;

    // memory stage to output side
    logic              done_valid;
    logic              done_ready;
    lsu_pkg::lsu_op_t  done_op;
    lsu_pkg::word_t    done_rdata;
    lsu_pkg::byte_en_t done_byte_en;

    lsu_issue_reg lsu_issue_reg_inst (
        .clk         (clk),
        .rst         (rst),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .req_ready_o (req_ready_o),
        .op_valid_o  (op_valid),
        .op_o        (op),
        .op_ready_i  (op_ready)
    );

    lsu_addr_gen lsu_addr_gen_inst (
        .clk             (clk),
        .rst             (rst),
        .op_valid_i      (op_valid),
        .op_i            (op),
        .op_ready_o      (op_ready),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_o       (mem_req_o),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_rdata_i (mem_rsp_rdata_i),
        .done_valid_o    (done_valid),
        .done_op_o       (done_op),
        .done_rdata_o    (done_rdata),
        .done_byte_en_o  (done_byte_en),
        .done_ready_i    (done_ready)
    );

    lsu_load_align lsu_load_align_inst (
        .clk            (clk),
        .rst            (rst),
        .done_valid_i   (done_valid),
        .done_op_i      (done_op),
        .done_rdata_i   (done_rdata),
        .done_byte_en_i (done_byte_en),
        .done_ready_o   (done_ready),
        .res_valid_o    (res_valid_o),
        .res_o          (res_o),
        .res_ready_i    (res_ready_i)
    );

endmodule : lsu_top

/* tb.f */
+incdir+hw
hw/lsu_pkg.sv
hw/lsu_issue_reg.sv
hw/lsu_addr_gen.sv
hw/lsu_load_align.sv
hw/lsu_top.sv
bench/lsu_asserts.sv
bench/lsu_tb.sv
